/* vlog.f */
cache_pkg.sv
cache_ctrl.sv
cache_way.sv
way_resolve.sv
write_through_buffer.sv
cache_top.sv
backing_mem_model.sv
cache_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module cache_tb -o cache_sim

# the run may stop on $fatal, the log decides
./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
   exit 1
fi
exit 0

/* cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
   import cache_pkg::*;

   localparam word_t FILL_XOR = 32'hc3a5_0f96;
   localparam int    TIMEOUT  = 2000;   // cycles per wait
   localparam logic [3:0] RH = 4'b1000;  // {read_hit, read_miss, write_hit, write_miss}
   localparam logic [3:0] RM = 4'b0100;
   localparam logic [3:0] WH = 4'b0010;
   localparam logic [3:0] WM = 4'b0001;

   logic       clk;
   logic       rst;
   logic       req_valid;
   addr_t      req_addr;
   word_t      req_wdata;
   strb_t      req_wstrb;
   wire        req_ready;
   word_t      req_rdata;
   wire        fill_req;
   line_addr_t fill_addr;
   wire        fill_valid;
   word_t      fill_data;
   wire        wr_valid;
   addr_t      wr_addr;
   word_t      wr_data;
   strb_t      wr_strb;
   wire        wr_ready;
   logic       invalidate;
   wire        read_hit;
   wire        read_miss;
   wire        write_hit;
   wire        write_miss;
   logic       stall_en;
   logic       hold_wr;

   integer      seed;
   word_t       shadow [2**ADDR_W];   // reference memory contents
   tag_t        m_tag  [2**INDEX_W][N_WAYS];
   logic        m_vld  [2**INDEX_W][N_WAYS];
   way_mask_t   m_plru [2**INDEX_W];
   string       test_name;
   logic [3:0]  exp_flags;
   logic        exp_is_read;
   word_t       exp_rdata;
   int          last_lat;             // negedges from drive to req_ready
   logic [51:0] wr_q [$];             // {addr, data, strb} in issue order
   logic [51:0] exp_w;
   logic [31:0] r;
   addr_t       ra;
   strb_t       rs;
   int          plru_seq [11] = '{0, 1, 2, 3, 4, 0, 1, 4, 2, 3, 0};  // tag order in one set

   cache_top dut_i (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_wstrb  (req_wstrb),
      .req_ready  (req_ready),
      .req_rdata  (req_rdata),
      .fill_req   (fill_req),
      .fill_addr  (fill_addr),
      .fill_valid (fill_valid),
      .fill_data  (fill_data),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_strb    (wr_strb),
      .wr_ready   (wr_ready),
      .invalidate (invalidate),
      .read_hit   (read_hit),
      .read_miss  (read_miss),
      .write_hit  (write_hit),
      .write_miss (write_miss)
   );

   backing_mem_model #(
      .FILL_XOR (FILL_XOR)
   ) mem_i (
      .clk        (clk),
      .rst        (rst),
      .stall_en   (stall_en),
      .hold_wr    (hold_wr),
      .fill_req   (fill_req),
      .fill_addr  (fill_addr),
      .fill_valid (fill_valid),
      .fill_data  (fill_data),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_strb    (wr_strb),
      .wr_ready   (wr_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic word_t ref_word(addr_t a);
      return shadow[a];
   endfunction

   task automatic check(string name, logic [63:0] exp, logic [63:0] act);
      if (exp !== act)
      begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         $display("Errors found");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic fail_msg(string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "stopping on timeout or protocol error");
   endtask

   // tag/valid/plru model
   task automatic model_clear();
      for (int i = 0; i < 2**INDEX_W; i++)
      begin
         m_plru[i] = '0;
         for (int w = 0; w < N_WAYS; w++)
         begin
            m_vld[i][w] = 1'b0;
            m_tag[i][w] = '0;
         end
      end
   endtask

   function automatic int find_way(index_t idx, tag_t t);
      for (int w = 0; w < N_WAYS; w++)
         if (m_vld[idx][w] && m_tag[idx][w] == t)
            return w;
      return -1;
   endfunction

   function automatic int pick_victim(index_t idx);
      for (int w = 0; w < N_WAYS; w++)
         if (!m_plru[idx][w])
            return w;  // lowest clear bit
      return 0;
   endfunction

   task automatic touch(index_t idx, int w);
      way_mask_t p;
      p = m_plru[idx] | way_mask_t'(1 << w);
      if (&p)
         p = '0;  // every way used so start again
      m_plru[idx] = p;
   endtask

   task automatic predict(addr_t a, logic is_wr, output logic [3:0] flags);
      index_t idx;
      tag_t   t;
      int     w;
      idx = a[OFFSET_W +: INDEX_W];
      t   = a[ADDR_W-1 -: TAG_W];
      w   = find_way(idx, t);
      if (is_wr)
      begin
         flags = (w >= 0) ? WH : WM;
         if (w >= 0)
            touch(idx, w);  // write miss leaves tags alone
      end
      else if (w >= 0)
      begin
         flags = RH;
         touch(idx, w);
      end
      else
      begin
         flags = RM;
         w = pick_victim(idx);
         m_tag[idx][w] = t;
         m_vld[idx][w] = 1'b1;
         touch(idx, w);
      end
   endtask

   task automatic shadow_write(addr_t a, word_t d, strb_t s);
      for (int b = 0; b < NBYTES; b++)
         if (s[b])
            shadow[a][8*b +: 8] = d[8*b +: 8];
   endtask

   task automatic start_req(addr_t a, word_t d, strb_t s);
      @(negedge clk);
      exp_is_read = (s == '0);
      exp_rdata   = ref_word(a);
      predict(a, s != '0, exp_flags);
      if (s != '0)
      begin
         shadow_write(a, d, s);
         wr_q.push_back({a, d, s});
      end
      req_valid = 1'b1;
      req_addr  = a;
      req_wdata = d;
      req_wstrb = s;
   endtask

   task automatic wait_ready();
      last_lat = 0;
      do
      begin
         @(negedge clk);
         last_lat++;
         if (last_lat > TIMEOUT)
            fail_msg("timeout: request never completed");
      end
      while (!req_ready);
      req_valid = 1'b0;
      req_wstrb = '0;
   endtask

   task automatic rd(addr_t a);
      start_req(a, '0, '0);
      wait_ready();
   endtask

   task automatic wr(addr_t a, word_t d, strb_t s);
      start_req(a, d, s);
      wait_ready();
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (wr_q.size() != 0 || wr_valid)
      begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT)
            fail_msg("timeout: write buffer never drained");
      end
   endtask

   // front-end compare at every falling edge
   always @(negedge clk)
   begin
      if (!rst && req_ready)
      begin
         check({test_name, " strobes"}, 64'(exp_flags),
               64'({read_hit, read_miss, write_hit, write_miss}));
         if (exp_is_read)
            check({test_name, " rdata"}, 64'(exp_rdata), 64'(req_rdata));
      end
      else if (!rst)
         check({test_name, " idle strobes"}, 64'(0),
               64'({read_hit, read_miss, write_hit, write_miss}));
   end

   // memory writes must come out in issue order
   always @(posedge clk)
   begin
      if (!rst && wr_valid && wr_ready)
      begin
         if (wr_q.size() == 0)
            fail_msg("memory write seen with nothing pending");
         else
         begin
            exp_w = wr_q.pop_front();
            check({test_name, " write order"}, 64'(exp_w), 64'({wr_addr, wr_data, wr_strb}));
         end
      end
   end

   initial
   begin
      seed       = 32'h23f3;
      rst        = 1'b1;
      req_valid  = 1'b0;
      req_addr   = '0;
      req_wdata  = '0;
      req_wstrb  = '0;
      invalidate = 1'b0;
      stall_en   = 1'b0;
      hold_wr    = 1'b0;
      exp_flags  = '0;
      exp_is_read = 1'b0;
      exp_rdata  = '0;
      test_name  = "reset";
      for (int i = 0; i < 2**ADDR_W; i++)
         shadow[i] = word_t'(i) ^ FILL_XOR;
      model_clear();
      repeat (5) @(negedge clk);
      rst = 1'b0;

      test_name = "cold read";
      rd(16'h1240);
      rd(16'h1241);  // same line now hits
      check("hit latency", 64'(2), 64'(last_lat));

      test_name = "partial write";
      rd(16'h2044);
      wr(16'h2045, 32'hdead_beef, 4'b0101);
      wr(16'h2046, 32'h1234_5678, 4'b1000);
      wr(16'h2045, 32'haabb_ccdd, 4'b0010);
      rd(16'h2045);
      rd(16'h2046);
      rd(16'h2044);

      test_name = "write miss";
      hold_wr = 1'b1;                        // both writes stay in the buffer
      wr(16'h3a10, 32'hcafe_f00d, 4'b1111);  // no allocate
      wr(16'h3a11, 32'h0bad_1dea, 4'b0011);
      start_req(16'h3a10, '0, '0);           // read miss has to wait for the drain
      repeat (4) @(negedge clk);
      hold_wr = 1'b0;
      wait_ready();
      rd(16'h3a11);

      test_name = "plru";
      for (int k = 0; k < 11; k++)
         rd({tag_t'(10'h100 + plru_seq[k]), 4'd9, 2'd1});  // five tags in one set

      test_name = "write stall";
      wait_drain();
      @(negedge clk);
      hold_wr = 1'b1;
      for (int i = 0; i < 4; i++)
         wr(addr_t'(16'h2044 + i), word_t'(32'h5500_0000 + i), 4'hf);
      start_req(16'h2048, 32'h7777_1111, 4'b1100);  // buffer is full now
      repeat (8)
      begin
         @(negedge clk);
         check("stalled ready", 64'(0), 64'(req_ready));
      end
      hold_wr = 1'b0;
      wait_ready();
      wait_drain();
      for (int i = 0; i < 5; i++)
         rd(addr_t'(16'h2044 + i));

      test_name = "invalidate";
      @(negedge clk);
      invalidate = 1'b1;
      model_clear();
      @(negedge clk);
      invalidate = 1'b0;
      rd(16'h1240);
      rd(16'h2045);
      rd({tag_t'(10'h100), 4'd9, 2'd1});

      test_name = "random mix";
      stall_en = 1'b1;
      for (int n = 0; n < 300; n++)
      begin
         r  = $random(seed);
         ra = '0;
         ra[ADDR_W-1 -: TAG_W]  = tag_t'(r[2:0]);   // few tags to get hits
         ra[OFFSET_W +: INDEX_W] = index_t'(r[5:4]);
         ra[OFFSET_W-1:0]       = r[9:8];
         rs = r[12] ? strb_t'(r[19:16]) : '0;
         if (r[12] && rs == '0)
            rs = 4'hf;
         wr(ra, $random(seed), rs);
      end
      wait_drain();
      stall_en = 1'b0;

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* backing_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module backing_mem_model #(
   parameter cache_pkg::word_t FILL_XOR = 32'h0
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        stall_en,    // random gaps on both channels
   input  wire                        hold_wr,     // keep wr_ready low
   // refill channel
   input  wire                        fill_req,
   input  wire cache_pkg::line_addr_t fill_addr,
   output logic                       fill_valid,
   output cache_pkg::word_t           fill_data,
   // write channel
   input  wire                        wr_valid,
   input  wire cache_pkg::addr_t      wr_addr,
   input  wire cache_pkg::word_t      wr_data,
   input  wire cache_pkg::strb_t      wr_strb,
   output logic                       wr_ready
);
   import cache_pkg::*;

   word_t       mem_array [2**ADDR_W];
   offset_t     beat;                  // next word of the line
   logic [31:0] r;
   integer      seed;

   initial
   begin
      seed = 32'h23f3;
      beat = '0;
      for (int i = 0; i < 2**ADDR_W; i++)
         mem_array[i] = word_t'(i) ^ FILL_XOR;  // same rule as the shadow copy
   end

   // outputs change on the falling edge only
   always @(negedge clk)
   begin
      r = $random(seed);
      if (rst)
      begin
         fill_valid <= 1'b0;
         fill_data  <= '0;
         wr_ready   <= 1'b0;
         beat = '0;
      end
      else
      begin
         if (!fill_req)
         begin
            fill_valid <= 1'b0;
            beat = '0;
         end
         else
         begin
            if (fill_valid)
               beat = beat + 1'b1;  // previous beat taken at the rising edge
            if (stall_en && r[1:0] == 2'b00)
               fill_valid <= 1'b0;  // gap
            else
            begin
               fill_valid <= 1'b1;
               fill_data  <= mem_array[{fill_addr, beat}];
            end
         end
         wr_ready <= !hold_wr && !(stall_en && r[3:2] == 2'b00);
      end
   end

   // writes land at the rising edge
   always @(posedge clk)
   begin
      if (!rst && wr_valid && wr_ready)
      begin
         for (int b = 0; b < NBYTES; b++)
         begin
            if (wr_strb[b])
               mem_array[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
   input  wire                        clk,
   input  wire                        rst,
   // front end
   input  wire                        req_valid,
   input  wire cache_pkg::addr_t      req_addr,
   input  wire cache_pkg::word_t      req_wdata,
   input  wire cache_pkg::strb_t      req_wstrb,
   output wire                        req_ready,
   output wire cache_pkg::word_t      req_rdata,
   // refill channel
   output wire                        fill_req,
   output wire cache_pkg::line_addr_t fill_addr,
   input  wire                        fill_valid,
   input  wire cache_pkg::word_t      fill_data,
   // write channel
   output wire                        wr_valid,
   output wire cache_pkg::addr_t      wr_addr,
   output wire cache_pkg::word_t      wr_data,
   output wire cache_pkg::strb_t      wr_strb,
   input  wire                        wr_ready,
   // control and counters
   input  wire                        invalidate,
   output wire                        read_hit,
   output wire                        read_miss,
   output wire                        write_hit,
   output wire                        write_miss
);
   import cache_pkg::*;

   wire way_mask_t         way_hit;
   wire way_mask_t         victim;
   wire way_mask_t         way_we;
   wire word_t [N_WAYS-1:0] way_rdata;
   wire                    arr_en;
   wire index_t            arr_index;
   wire tag_t              arr_tag;
   wire offset_t           arr_offset;
   wire strb_t             line_we;
   wire word_t             line_wdata;
   wire                    set_valid;
   wire                    clear_all;
   wire                    plru_update;
   wire                    wtbuf_push;
   wire                    wtbuf_full;
   wire                    wtbuf_empty;

   cache_ctrl ctrl_i (
      .clk         (clk),
      .rst         (rst),
      .req_valid   (req_valid),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_wstrb   (req_wstrb),
      .req_ready   (req_ready),
      .invalidate  (invalidate),
      .way_hit     (way_hit),
      .victim      (victim),
      .fill_req    (fill_req),
      .fill_addr   (fill_addr),
      .fill_valid  (fill_valid),
      .fill_data   (fill_data),
      .wtbuf_full  (wtbuf_full),
      .wtbuf_empty (wtbuf_empty),
      .arr_en      (arr_en),
      .arr_index   (arr_index),
      .arr_tag     (arr_tag),
      .arr_offset  (arr_offset),
      .way_we      (way_we),
      .line_we     (line_we),
      .line_wdata  (line_wdata),
      .set_valid   (set_valid),
      .clear_all   (clear_all),
      .plru_update (plru_update),
      .wtbuf_push  (wtbuf_push),
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss)
   );

   for (genvar g = 0; g < N_WAYS; g++)
   begin : g_way
      cache_way way_i (
         .clk       (clk),
         .rst       (rst),
         .en        (arr_en),
         .index     (arr_index),
         .tag       (arr_tag),
         .offset    (arr_offset),
         .we        (line_we & {NBYTES{way_we[g]}}),  // only this way's enable
         .wdata     (line_wdata),
         .set_valid (set_valid),
         .clear_all (clear_all),
         .hit       (way_hit[g]),
         .rdata     (way_rdata[g])
      );
   end

   way_resolve resolve_i (
      .clk       (clk),
      .rst       (rst),
      .index     (arr_index),
      .way_hit   (way_hit),
      .way_rdata (way_rdata),
      .update    (plru_update),
      .clear_all (clear_all),
      .hit_any   (),
      .rdata     (req_rdata),
      .victim    (victim)
   );

   // write address rebuilt from the held request fields
   write_through_buffer #(
      .DEPTH_W (WTBUF_DEPTH_W)
   ) wtbuf_i (
      .clk       (clk),
      .rst       (rst),
      .push      (wtbuf_push),
      .push_addr ({arr_tag, arr_index, arr_offset}),
      .push_data (line_wdata),
      .push_strb (line_we),
      .wr_valid  (wr_valid),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_strb   (wr_strb),
      .wr_ready  (wr_ready),
      .full      (wtbuf_full),
      .empty     (wtbuf_empty)
   );

endmodule

`default_nettype wire

/* write_through_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_through_buffer #(
   parameter int DEPTH_W = 2
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   push,
   input  wire cache_pkg::addr_t push_addr,
   input  wire cache_pkg::word_t push_data,
   input  wire cache_pkg::strb_t push_strb,
   // memory write channel
   output logic                  wr_valid,
   output cache_pkg::addr_t      wr_addr,
   output cache_pkg::word_t      wr_data,
   output cache_pkg::strb_t      wr_strb,
   input  wire                   wr_ready,
   output logic                  full,
   output logic                  empty
);
   import cache_pkg::*;

   addr_t              addr_mem [2**DEPTH_W];
   word_t              data_mem [2**DEPTH_W];
   strb_t              strb_mem [2**DEPTH_W];
   logic [DEPTH_W-1:0] head;    // oldest entry
   logic [DEPTH_W-1:0] tail;    // next free slot
   logic [DEPTH_W:0]   count;
   logic               push_ok;
   logic               pop;

   assign push_ok = push && !full;
   assign pop     = wr_valid && wr_ready;
   assign empty   = (count == '0);
   assign full    = (count == (DEPTH_W+1)'(2**DEPTH_W));

   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         addr_mem[tail] <= push_addr;
         data_mem[tail] <= push_data;
         strb_mem[tail] <= push_strb;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         if (push_ok)
            tail <= tail + 1'b1;  // pointers wrap with the depth
         if (pop)
            head <= head + 1'b1;
         case ({push_ok, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head entry sits directly on the channel
   assign wr_valid = !empty;
   assign wr_addr  = addr_mem[head];
   assign wr_data  = data_mem[head];
   assign wr_strb  = strb_mem[head];

endmodule

`default_nettype wire

/* way_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module way_resolve (
   input  wire                                           clk,
   input  wire                                           rst,
   input  wire cache_pkg::index_t                        index,
   input  wire cache_pkg::way_mask_t                     way_hit,
   input  wire cache_pkg::word_t [cache_pkg::N_WAYS-1:0] way_rdata,
   input  wire                                           update,
   input  wire                                           clear_all,
   output logic                                          hit_any,
   output cache_pkg::word_t                              rdata,
   output cache_pkg::way_mask_t                          victim
);
   import cache_pkg::*;

   way_mask_t        plru_q [2**INDEX_W];  // bit set = recently used
   way_mask_t        plru_cur;
   way_mask_t        touch;
   way_mask_t        plru_or;
   logic [WAY_W-1:0] hit_idx;

   assign hit_any = |way_hit;

   // at most one way hits, encode it for the data mux
   always_comb
   begin
      hit_idx = '0;
      for (int w = 0; w < N_WAYS; w++)
      begin
         if (way_hit[w])
            hit_idx = WAY_W'(w);
      end
   end

   assign rdata    = way_rdata[hit_idx];
   assign plru_cur = plru_q[index];

   // lowest way with a clear bit
   always_comb
   begin
      victim = '0;
      for (int w = N_WAYS - 1; w >= 0; w--)
      begin
         if (!plru_cur[w])
            victim = way_mask_t'(1 << w);
      end
   end

   // on a refill nothing hits yet, so the filled way is the victim
   assign touch   = hit_any ? way_hit : victim;
   assign plru_or = plru_cur | touch;

   always_ff @(posedge clk)
   begin
      if (rst || clear_all)
      begin
         for (int i = 0; i < 2**INDEX_W; i++)
            plru_q[i] <= '0;
      end
      else if (update)
      begin
         plru_q[index] <= (&plru_or) ? '0 : plru_or;  // all used, start over
      end
   end

endmodule

`default_nettype wire

/* cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   en,         // read (and write) enable
   input  wire cache_pkg::index_t  index,
   input  wire cache_pkg::tag_t    tag,      // tag of the current request
   input  wire cache_pkg::offset_t offset,
   input  wire cache_pkg::strb_t   we,       // byte enables, already gated for this way
   input  wire cache_pkg::word_t   wdata,
   input  wire                   set_valid,
   input  wire                   clear_all,
   output logic                  hit,
   output cache_pkg::word_t      rdata
);
   import cache_pkg::*;

   word_t                 data_mem [2**INDEX_W][LINE_WORDS];
   tag_t                  tag_mem  [2**INDEX_W];
   logic [2**INDEX_W-1:0] valid_q;   // one bit per line
   tag_t                  tag_rd;
   logic                  valid_rd;
   logic                  fill_line;

   assign fill_line = en && set_valid && (|we);

   // byte-enabled data array, read-first
   always_ff @(posedge clk)
   begin
      if (en)
      begin
         for (int b = 0; b < NBYTES; b++)
         begin
            if (we[b])
               data_mem[index][offset][8*b +: 8] <= wdata[8*b +: 8];
         end
         rdata <= data_mem[index][offset];
      end
   end

   // tag array, written only during refill
   always_ff @(posedge clk)
   begin
      if (fill_line)
         tag_mem[index] <= tag;
      if (en)
         tag_rd <= tag_mem[index];
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_all)
      begin
         valid_q  <= '0;  // invalidate drops every line at once
         valid_rd <= 1'b0;
      end
      else
      begin
         if (fill_line)
            valid_q[index] <= 1'b1;
         if (en)
            valid_rd <= valid_q[index];
      end
   end

   assign hit = valid_rd && (tag_rd == tag);  // compare in the lookup cycle

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  wire                     clk,
   input  wire                     rst,
   // front end
   input  wire                     req_valid,
   input  wire cache_pkg::addr_t   req_addr,
   input  wire cache_pkg::word_t   req_wdata,
   input  wire cache_pkg::strb_t   req_wstrb,
   output logic                    req_ready,
   input  wire                     invalidate,
   // from the ways and the resolver
   input  wire cache_pkg::way_mask_t way_hit,
   input  wire cache_pkg::way_mask_t victim,
   // refill channel
   output logic                    fill_req,
   output cache_pkg::line_addr_t   fill_addr,
   input  wire                     fill_valid,
   input  wire cache_pkg::word_t   fill_data,
   // write-through buffer status
   input  wire                     wtbuf_full,
   input  wire                     wtbuf_empty,
   // array access, shared by all ways
   output logic                    arr_en,
   output cache_pkg::index_t       arr_index,
   output cache_pkg::tag_t         arr_tag,
   output cache_pkg::offset_t      arr_offset,
   output cache_pkg::way_mask_t    way_we,
   output cache_pkg::strb_t        line_we,
   output cache_pkg::word_t        line_wdata,
   output logic                    set_valid,
   output logic                    clear_all,
   output logic                    plru_update,
   output logic                    wtbuf_push,
   // counter strobes
   output logic                    read_hit,
   output logic                    read_miss,
   output logic                    write_hit,
   output logic                    write_miss
);
   import cache_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,      // tag compare result available
      S_WRITE_WAIT,  // buffer full, write held
      S_DRAIN,       // read miss waits for an empty buffer
      S_REFILL,
      S_RELOOK,      // re-read the arrays after the last beat
      S_RESP         // read data out, req_ready
   } state_t;

   state_t  state;
   state_t  state_nxt;
   addr_t   req_addr_q;      // request register
   word_t   req_wdata_q;
   strb_t   req_wstrb_q;
   offset_t beat_cnt;        // refill word counter
   logic    missed;          // this read went through a refill
   logic    accept;
   logic    is_write;
   logic    hit;
   logic    wr_done;
   logic    rd_done;
   logic    last_beat;

   assign accept    = (state == S_IDLE) && req_valid && !invalidate;
   assign is_write  = |req_wstrb_q;  // zero strobes means read
   assign hit       = |way_hit;
   assign wr_done   = is_write && !wtbuf_full
                      && (state == S_LOOKUP || state == S_WRITE_WAIT);
   assign rd_done   = (state == S_RESP);
   assign last_beat = (state == S_REFILL) && fill_valid
                      && (beat_cnt == offset_t'(LINE_WORDS - 1));

   always_comb
   begin
      state_nxt = state;
      case (state)
         S_IDLE:
            if (accept)
               state_nxt = S_LOOKUP;
         S_LOOKUP:
         begin
            if (is_write)
               state_nxt = wtbuf_full ? S_WRITE_WAIT : S_IDLE;
            else
               state_nxt = hit ? S_RESP : S_DRAIN;
         end
         S_WRITE_WAIT:
            if (!wtbuf_full)
               state_nxt = S_IDLE;
         S_DRAIN:
            if (wtbuf_empty)
               state_nxt = S_REFILL;  // memory holds every earlier write
         S_REFILL:
            if (last_beat)
               state_nxt = S_RELOOK;
         S_RELOOK:
            state_nxt = S_LOOKUP;
         S_RESP:
            state_nxt = S_IDLE;
         default:
            state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= S_IDLE;
         missed   <= 1'b0;
         beat_cnt <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (accept)
            missed <= 1'b0;
         else if (state == S_LOOKUP && !is_write && !hit)
            missed <= 1'b1;
         if (state == S_DRAIN)
            beat_cnt <= '0;
         else if (state == S_REFILL && fill_valid)
            beat_cnt <= beat_cnt + 1'b1;  // beats may have gaps
      end
   end

   // request fields, held for the whole access
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req_addr_q  <= req_addr;
         req_wdata_q <= req_wdata;
         req_wstrb_q <= req_wstrb;
      end
   end

   // the accepting edge already reads the arrays, so idle uses the live address
   assign arr_index  = (state == S_IDLE) ? req_addr[OFFSET_W +: INDEX_W]
                                         : req_addr_q[OFFSET_W +: INDEX_W];
   assign arr_tag    = req_addr_q[ADDR_W-1 -: TAG_W];
   assign arr_offset = fill_req ? beat_cnt
                     : (state == S_IDLE) ? req_addr[OFFSET_W-1:0]
                     : req_addr_q[OFFSET_W-1:0];
   assign arr_en     = accept || wr_done || (fill_req && fill_valid)
                       || (state == S_RELOOK);

   // write steering
   always_comb
   begin
      way_we     = '0;
      line_we    = req_wstrb_q;
      line_wdata = req_wdata_q;
      if (fill_req)
      begin
         way_we     = fill_valid ? victim : '0;  // whole word into the victim
         line_we    = '1;
         line_wdata = fill_data;
      end
      else if (wr_done)
      begin
         way_we = way_hit;  // no allocate on a write miss
      end
   end

   assign fill_req    = (state == S_REFILL);
   assign fill_addr   = req_addr_q[ADDR_W-1:OFFSET_W];
   assign set_valid   = fill_req && fill_valid;  // tag written with each beat
   assign clear_all   = (state == S_IDLE) && invalidate;
   assign wtbuf_push  = wr_done;                 // every write goes to memory
   assign plru_update = (wr_done && hit) || (rd_done && !missed) || last_beat;

   assign req_ready   = wr_done || rd_done;
   assign read_hit    = rd_done && !missed;
   assign read_miss   = rd_done && missed;
   assign write_hit   = wr_done && hit;
   assign write_miss  = wr_done && !hit;

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

   // word-addressed front end
   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int NBYTES        = DATA_W / 8;     // byte lanes per word

   // cache geometry
   localparam int N_WAYS        = 4;
   localparam int WAY_W         = 2;              // log2 of N_WAYS
   localparam int INDEX_W       = 4;              // 16 sets
   localparam int OFFSET_W      = 2;
   localparam int LINE_WORDS    = 4;              // 2**OFFSET_W words per line
   localparam int TAG_W         = ADDR_W - INDEX_W - OFFSET_W;

   // pending memory writes, 2**WTBUF_DEPTH_W entries
   localparam int WTBUF_DEPTH_W = 2;

   // word address layout is {tag, index, offset}
   typedef logic [DATA_W-1:0]         word_t;
   typedef logic [NBYTES-1:0]         strb_t;
   typedef logic [ADDR_W-1:0]         addr_t;
   typedef logic [TAG_W-1:0]          tag_t;
   typedef logic [INDEX_W-1:0]        index_t;
   typedef logic [OFFSET_W-1:0]       offset_t;
   typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;  // tag and index, as sent on refill
   typedef logic [N_WAYS-1:0]         way_mask_t;   // one bit per way

endpackage

`default_nettype wire
